//--- common/rvPkg.sv
package rvPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // major opcodes of the base ISA
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    // passB forwards the second operand unchanged, which is all LUI needs.
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluPassB
    } aluOp_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded controls of one instruction
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic        regWrite;
        logic        aluSrc;   // second operand is the immediate.
        logic        branch;
        logic        memRead;
        logic        memWrite;
        logic        memToReg;
        logic        jal;
        logic        jalr;
        logic        auipc;    // first operand is the pc.
        aluOp_t      aluOp;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
    } ctrl_t;

    // one word-sized data memory request.
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] storeData;
        logic        read;
        logic        write;
    } dataReq_t;

endpackage

//--- src/registerFile.sv
`timescale 1ns/100ps

module registerFile (
    input  logic        clk,
    input  logic        rst,
    input  logic        writeEnable,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] writeData,
    output logic [31:0] readData1,
    output logic [31:0] readData2
);

    logic [31:0] regs [32];

    // x0 is never written, so it reads back as zero after reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != 5'd0)) begin
            regs[rd] <= writeData;
        end
    end

    assign readData1 = regs[rs1];
    assign readData2 = regs[rs2];

endmodule

//--- src/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
    input  logic [31:0]  instruction,
    output rvPkg::ctrl_t ctrl
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic        funct7b5;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // shared by OP and OP-IMM. Only register ops know SUB, both know SRA.
    function automatic rvPkg::aluOp_t aluDecode(
        input logic [2:0] f3,
        input logic       alt,
        input logic       regOp
    );
        rvPkg::aluOp_t op;
        case (f3)
            3'b000:  op = (regOp && alt) ? rvPkg::aluSub : rvPkg::aluAdd;
            3'b001:  op = rvPkg::aluSll;
            3'b010:  op = rvPkg::aluSlt;
            3'b011:  op = rvPkg::aluSltu;
            3'b100:  op = rvPkg::aluXor;
            3'b101:  op = alt ? rvPkg::aluSra : rvPkg::aluSrl;
            3'b110:  op = rvPkg::aluOr;
            default: op = rvPkg::aluAnd;
        endcase
        return op;
    endfunction

    assign opcode   = instruction[6:0];
    assign funct3   = instruction[14:12];
    assign funct7b5 = instruction[30];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // immediates sign extended from bit 31
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    always_comb begin
        ctrl       = '0;
        ctrl.aluOp = rvPkg::aluAdd;
        ctrl.rs1   = instruction[19:15];
        ctrl.rs2   = instruction[24:20];
        ctrl.rd    = instruction[11:7];
        case (opcode)
            rvPkg::opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = rvPkg::aluPassB;
                ctrl.imm      = immU;
            end
            rvPkg::opAuipc: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.auipc    = 1'b1;
                ctrl.imm      = immU;
            end
            rvPkg::opJal: begin
                ctrl.regWrite = 1'b1;
                ctrl.jal      = 1'b1;
                ctrl.imm      = immJ;
            end
            rvPkg::opJalr: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1; // target is rs1 plus offset.
                ctrl.jalr     = 1'b1;
                ctrl.imm      = immI;
            end
            rvPkg::opBranch: begin
                ctrl.branch = 1'b1;
                ctrl.imm    = immB;
            end
            rvPkg::opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.imm      = immI;
            end
            rvPkg::opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.imm      = immS;
            end
            rvPkg::opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluDecode(funct3, funct7b5, 1'b0);
                ctrl.imm      = immI;
            end
            rvPkg::opOp: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluDecode(funct3, funct7b5, 1'b1);
            end
            default: ctrl.regWrite = 1'b0; // anything else retires as a no-op.
        endcase
    end

endmodule

//--- src/alu.sv
`timescale 1ns/100ps

module alu (
    input  logic [31:0]   srcA,
    input  logic [31:0]   srcB,
    input  rvPkg::aluOp_t aluOp,
    input  logic [2:0]    funct3,
    output logic [31:0]   result,
    output logic          branchTaken
);

    logic [4:0] shamt;
    logic       isEqual;
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt        = srcB[4:0];
    assign isEqual      = (srcA == srcB);
    assign lessSigned   = ($signed(srcA) < $signed(srcB));
    assign lessUnsigned = (srcA < srcB);

    always_comb begin
        case (aluOp)
            rvPkg::aluAdd:   result = srcA + srcB;
            rvPkg::aluSub:   result = srcA - srcB;
            rvPkg::aluSll:   result = srcA << shamt;
            rvPkg::aluSlt:   result = {31'b0, lessSigned};
            rvPkg::aluSltu:  result = {31'b0, lessUnsigned};
            rvPkg::aluXor:   result = srcA ^ srcB;
            rvPkg::aluSrl:   result = srcA >> shamt;
            rvPkg::aluSra:   result = $unsigned($signed(srcA) >>> shamt);
            rvPkg::aluOr:    result = srcA | srcB;
            rvPkg::aluAnd:   result = srcA & srcB;
            rvPkg::aluPassB: result = srcB;
            default:         result = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch condition
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // funct3 picks the compare, the caller decides whether it matters.
    always_comb begin
        case (funct3)
            3'b000:  branchTaken = isEqual;
            3'b001:  branchTaken = !isEqual;
            3'b100:  branchTaken = lessSigned;
            3'b101:  branchTaken = !lessSigned;
            3'b110:  branchTaken = lessUnsigned;
            3'b111:  branchTaken = !lessUnsigned;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

//--- src/pcUnit.sv
`timescale 1ns/100ps

module pcUnit #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        commit,
    input  logic        branch,
    input  logic        branchTaken,
    input  logic        jal,
    input  logic        jalr,
    input  logic [31:0] imm,
    input  logic [31:0] jalrTarget,
    output logic [31:0] pc,
    output logic [31:0] pcPlus4
);

    assign pcPlus4 = pc + 32'd4;

    // the pc only moves when an instruction retires.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetVector;
        end else if (commit) begin
            if (jalr) begin
                pc <= {jalrTarget[31:1], 1'b0};
            end else if (jal || (branch && branchTaken)) begin
                pc <= pc + imm;
            end else begin
                pc <= pcPlus4;
            end
        end
    end

endmodule

//--- src/requestUnit.sv
`timescale 1ns/100ps

module requestUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            iAck,
    input  logic            dAck,
    input  logic [31:0]     instruction,
    input  logic            memRead,
    input  logic            memWrite,
    input  logic [31:0]     memAddress,
    input  logic [31:0]     storedData,
    output logic            fetching,
    output logic [31:0]     currentInstr,
    output rvPkg::dataReq_t dataReq,
    output logic            commit
);

    typedef enum logic {
        stFetch,
        stExecute
    } state_t;

    state_t state;
    logic   memAccess;

    assign memAccess = memRead || memWrite;
    assign fetching  = (state == stFetch);

    // retire right away unless the instruction waits for data memory.
    assign commit = (state == stExecute) && (!memAccess || dAck);

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= stFetch;
            currentInstr <= '0; // decodes as a no-op.
        end else begin
            case (state)
                stFetch: begin
                    if (iAck) begin
                        currentInstr <= instruction;
                        state        <= stExecute;
                    end
                end
                default: if (commit) state <= stFetch;
            endcase
        end
    end

    // address and data stay put while the register file and pc are frozen.
    assign dataReq.address   = memAddress;
    assign dataReq.storeData = storedData;
    assign dataReq.read      = (state == stExecute) && memRead;
    assign dataReq.write     = (state == stExecute) && memWrite;

endmodule

//--- src/datapath.sv
`timescale 1ns/100ps

module datapath #(
    parameter logic [31:0] resetVector = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            iAck,
    input  logic            dAck,
    input  logic [31:0]     instruction,
    input  logic [31:0]     memLoad,
    output logic [31:0]     iAddress,
    output rvPkg::dataReq_t dataReq
);

    rvPkg::ctrl_t ctrl;
    logic [31:0]  currentInstr;
    logic         fetching;
    logic         commit;
    logic [31:0]  readData1;
    logic [31:0]  readData2;
    logic [31:0]  srcA;
    logic [31:0]  srcB;
    logic [31:0]  aluResult;
    logic         branchTaken;
    logic [31:0]  pc;
    logic [31:0]  pcPlus4;
    logic [31:0]  writeBackData;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode and register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    controlUnit controlUnit_i (
        .instruction (currentInstr),
        .ctrl        (ctrl)
    );

    registerFile registerFile_i (
        .clk         (clk),
        .rst         (rst),
        .writeEnable (ctrl.regWrite && commit),
        .rs1         (ctrl.rs1),
        .rs2         (ctrl.rs2),
        .rd          (ctrl.rd),
        .writeData   (writeBackData),
        .readData1   (readData1),
        .readData2   (readData2)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign srcA = ctrl.auipc ? pc : readData1;
    assign srcB = ctrl.aluSrc ? ctrl.imm : readData2;

    alu alu_i (
        .srcA        (srcA),
        .srcB        (srcB),
        .aluOp       (ctrl.aluOp),
        .funct3      (currentInstr[14:12]),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    // links take pc plus 4, loads take the memory word.
    always_comb begin
        if (ctrl.memToReg) begin
            writeBackData = memLoad;
        end else if (ctrl.jal || ctrl.jalr) begin
            writeBackData = pcPlus4;
        end else begin
            writeBackData = aluResult;
        end
    end

    pcUnit #(
        .resetVector (resetVector)
    ) pcUnit_i (
        .clk         (clk),
        .rst         (rst),
        .commit      (commit),
        .branch      (ctrl.branch),
        .branchTaken (branchTaken),
        .jal         (ctrl.jal),
        .jalr        (ctrl.jalr),
        .imm         (ctrl.imm),
        .jalrTarget  (aluResult),
        .pc          (pc),
        .pcPlus4     (pcPlus4)
    );

    requestUnit requestUnit_i (
        .clk          (clk),
        .rst          (rst),
        .iAck         (iAck),
        .dAck         (dAck),
        .instruction  (instruction),
        .memRead      (ctrl.memRead),
        .memWrite     (ctrl.memWrite),
        .memAddress   (aluResult),
        .storedData   (readData2),
        .fetching     (fetching),
        .currentInstr (currentInstr),
        .dataReq      (dataReq),
        .commit       (commit)
    );

    assign iAddress = fetching ? pc : 32'd0; // idle while an instruction executes.

endmodule

//--- dv/memModel.sv
`timescale 1ns/100ps

module memModel #(
    parameter int maxDelay = 3
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     iAddress,
    input  rvPkg::dataReq_t dataReq,
    output logic            iAck,
    output logic            dAck,
    output logic [31:0]     instruction,
    output logic [31:0]     memLoad
);

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] logAddr [$];  // every store in the order memory saw it.
    logic [31:0] logData [$];
    int          iWait;
    int          iDelay;
    int          dWait;
    int          dDelay;

    initial begin
        void'($urandom(64));
        iAck        = 1'b0;
        dAck        = 1'b0;
        instruction = '0;
        memLoad     = '0;
        iWait       = 0;
        dWait       = 0;
        iDelay      = $urandom_range(maxDelay, 0);
        dDelay      = $urandom_range(maxDelay, 0);
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = ((i * 4) * 32'h0100_0193) ^ 32'hDEAD_BEEF; // mixes the whole address.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // acknowledge generation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // an address of zero means the core is not fetching.
    always @(negedge clk) begin
        if (rst) begin
            iAck  <= 1'b0;
            dAck  <= 1'b0;
            iWait <= 0;
            dWait <= 0;
        end else begin
            if (iAck) begin
                iAck   <= 1'b0; // the request was taken at the last edge.
                iWait  <= 0;
                iDelay <= $urandom_range(maxDelay, 0);
            end else if (iAddress != 32'd0) begin
                if (iWait >= iDelay) begin
                    iAck        <= 1'b1;
                    instruction <= imem[iAddress[9:2]];
                end else begin
                    iWait <= iWait + 1;
                end
            end
            if (dAck) begin
                dAck   <= 1'b0;
                dWait  <= 0;
                dDelay <= $urandom_range(maxDelay, 0);
            end else if (dataReq.read || dataReq.write) begin
                if (dWait >= dDelay) begin
                    dAck    <= 1'b1;
                    memLoad <= dmem[dataReq.address[9:2]];
                end else begin
                    dWait <= dWait + 1;
                end
            end
        end
    end

    // stores land at the acknowledge edge.
    always @(posedge clk) begin
        if (!rst && dAck && dataReq.write) begin
            dmem[dataReq.address[9:2]] <= dataReq.storeData;
            logAddr.push_back(dataReq.address);
            logData.push_back(dataReq.storeData);
        end
    end

endmodule

//--- dv/datapathTb.sv
`timescale 1ns/100ps

module datapathTb;

    localparam logic [31:0] resetVector = 32'h0000_0100;
    localparam int          maxDelay    = 3;
    localparam int          period      = 8;

    logic            clk;
    logic            rst;
    logic            iAck;
    logic            dAck;
    logic [31:0]     instruction;
    logic [31:0]     memLoad;
    logic [31:0]     iAddress;
    rvPkg::dataReq_t dataReq;

    string       rowName [$];
    logic [31:0] rowAddr [$];
    logic [31:0] rowValue [$];
    int          pcIdx;
    logic [31:0] storeSlot;
    int          passCount;
    int          failCount;
    logic        tableBuilt;
    logic [31:0] markPc;

    datapath #(.resetVector(resetVector)) datapath_i (
        .clk(clk), .rst(rst), .iAck(iAck), .dAck(dAck), .instruction(instruction),
        .memLoad(memLoad), .iAddress(iAddress), .dataReq(dataReq)
    );

    memModel #(.maxDelay(maxDelay)) memModel_i (
        .clk(clk), .rst(rst), .iAddress(iAddress), .dataReq(dataReq), .iAck(iAck),
        .dAck(dAck), .instruction(instruction), .memLoad(memLoad)
    );

    always #(period / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] encR(input logic [6:0] f7, input int rs2, input int rs1,
                                         input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], rvPkg::opOp};
    endfunction

    function automatic logic [31:0] encI(input int imm, input int rs1, input logic [2:0] f3,
                                         input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic logic [31:0] encB(input int imm, input int rs2, input int rs1,
                                         input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11],
                rvPkg::opBranch};
    endfunction

    function automatic logic [31:0] encU(input int imm20, input int rd, input logic [6:0] op);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] encJ(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rvPkg::opJal};
    endfunction

    function automatic logic [31:0] currentPc();
        return resetVector + 32'(4 * pcIdx);
    endfunction

    task automatic emit(input logic [31:0] ins);
        memModel_i.imem[(resetVector >> 2) + pcIdx] = ins;
        pcIdx++;
    endtask

    // stores a register to the next result slot and records the expected word.
    task automatic storeResult(input int rs, input string name, input logic [31:0] value);
        emit(encS(storeSlot, rs, 0));
        rowName.push_back(name);
        rowAddr.push_back(storeSlot);
        rowValue.push_back(value);
        storeSlot += 4;
    endtask

    // x5 ends up 2 when the branch is taken and 1 when it falls through.
    task automatic branchCase(input string name, input logic [2:0] f3, input int rsA,
                              input int rsB, input logic taken);
        emit(encB(12, rsB, rsA, f3));
        emit(encI(1, 0, 3'b000, 5, rvPkg::opOpImm));
        emit(encJ(8, 0));
        emit(encI(2, 0, 3'b000, 5, rvPkg::opOpImm));
        storeResult(5, name, taken ? 32'd2 : 32'd1);
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (expected === actual) begin
            $display("ok     %s", name);
            passCount++;
        end else begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            failCount++;
        end
    endtask

    task automatic buildProgram();
        emit(encI(100, 0, 3'b000, 1, rvPkg::opOpImm));  // x1 = 100
        emit(encI(-7, 0, 3'b000, 2, rvPkg::opOpImm));   // x2 = -7
        emit(encR(7'h00, 2, 1, 3'b000, 3));
        storeResult(3, "add", 32'd93);
        emit(encR(7'h20, 2, 1, 3'b000, 3));
        storeResult(3, "sub", 32'd107);
        emit(encR(7'h00, 2, 1, 3'b111, 3));
        storeResult(3, "and", 32'h0000_0060);
        emit(encR(7'h00, 2, 1, 3'b110, 3));
        storeResult(3, "or", 32'hFFFF_FFFD);
        emit(encR(7'h00, 2, 1, 3'b100, 3));
        storeResult(3, "xor", 32'hFFFF_FF9D);
        emit(encR(7'h00, 1, 2, 3'b010, 3));
        storeResult(3, "slt", 32'd1);
        emit(encR(7'h00, 1, 2, 3'b011, 3));
        storeResult(3, "sltu", 32'd0);
        emit(encI(4, 1, 3'b001, 3, rvPkg::opOpImm));
        storeResult(3, "slli", 32'h0000_0640);
        emit(encI(32'h401, 2, 3'b101, 3, rvPkg::opOpImm));
        storeResult(3, "srai", 32'hFFFF_FFFC);
        emit(encI(28, 2, 3'b101, 3, rvPkg::opOpImm));
        storeResult(3, "srli", 32'h0000_000F);
        emit(encU(32'h12345, 3, rvPkg::opLui));
        storeResult(3, "lui", 32'h1234_5000);
        markPc = currentPc();
        emit(encU(1, 3, rvPkg::opAuipc));
        storeResult(3, "auipc", markPc + 32'h1000);
        emit(encI(5, 1, 3'b000, 0, rvPkg::opOpImm));     // write to x0 is dropped.
        storeResult(0, "x0 write", 32'd0);
        emit(encI(32'h300, 0, 3'b010, 4, rvPkg::opLoad));
        storeResult(4, "lw", 32'hCAFE_F00D);

        branchCase("beq taken", 3'b000, 1, 1, 1'b1);
        branchCase("beq not taken", 3'b000, 1, 2, 1'b0);
        branchCase("bne taken", 3'b001, 1, 2, 1'b1);
        branchCase("bne not taken", 3'b001, 1, 1, 1'b0);
        branchCase("blt taken", 3'b100, 2, 1, 1'b1);
        branchCase("blt not taken", 3'b100, 1, 2, 1'b0);
        branchCase("bge taken", 3'b101, 1, 2, 1'b1);
        branchCase("bge not taken", 3'b101, 2, 1, 1'b0);
        branchCase("bltu taken", 3'b110, 1, 2, 1'b1);
        branchCase("bltu not taken", 3'b110, 2, 1, 1'b0);
        branchCase("bgeu taken", 3'b111, 2, 1, 1'b1);
        branchCase("bgeu not taken", 3'b111, 1, 2, 1'b0);

        // skipped slots hold stores, so a wrong target shows up in the log.
        markPc = currentPc();
        emit(encJ(12, 6));
        emit(encS(32'h3F0, 0, 0));
        emit(encS(32'h3F0, 0, 0));
        storeResult(6, "jal link", markPc + 32'd4);
        markPc = currentPc();
        emit(encU(0, 8, rvPkg::opAuipc));
        emit(encI(16, 8, 3'b000, 9, rvPkg::opJalr));
        emit(encS(32'h3F4, 0, 0));
        emit(encS(32'h3F4, 0, 0));
        storeResult(9, "jalr link", markPc + 32'd8);
        emit(encJ(0, 0)); // park here.
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // watchdog
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        wait (tableBuilt === 1'b1);
        #(rowName.size() * 40 * (maxDelay + 2) * period);
        $display("timeout: the program stalled before all stores were seen");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pcIdx      = 0;
        storeSlot  = 32'h200;
        passCount  = 0;
        failCount  = 0;
        tableBuilt = 1'b0;
        #1;
        memModel_i.dmem[32'h300 >> 2] = 32'hCAFE_F00D;
        buildProgram();
        tableBuilt = 1'b1;

        repeat (2) @(negedge clk);
        rst = 1'b0;
        #1;
        checkValue("reset state", {resetVector, 32'd0},
                   {iAddress, 30'd0, dataReq.read, dataReq.write});

        for (int i = 0; i < rowName.size(); i++) begin
            while (memModel_i.logAddr.size() <= i) begin
                @(posedge clk);
            end
            checkValue(rowName[i], {rowAddr[i], rowValue[i]},
                       {memModel_i.logAddr[i], memModel_i.logData[i]});
        end

        repeat (50) @(posedge clk);
        if (memModel_i.logAddr.size() != rowName.size()) begin
            $display("the store log holds %0d stores where %0d were expected",
                     memModel_i.logAddr.size(), rowName.size());
            failCount++;
        end

        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- sim.f
common/rvPkg.sv
src/registerFile.sv
src/controlUnit.sv
src/alu.sv
src/pcUnit.sv
src/requestUnit.sv
src/datapath.sv
dv/memModel.sv
dv/datapathTb.sv

//--- Bender.yml
package:
  name: rv32iCore

sources:
  - common/rvPkg.sv
  - src/registerFile.sv
  - src/controlUnit.sv
  - src/alu.sv
  - src/pcUnit.sv
  - src/requestUnit.sv
  - src/datapath.sv
  - target: test
    files:
      - dv/memModel.sv
      - dv/datapathTb.sv
